// File: hdl/pinmux_pkg.sv
package pinmux_pkg;

   //------------------------------
   // Bus geometry
   //------------------------------
   localparam int unsigned DATA_W    = 32;              // Register bus data width
   localparam int unsigned BE_W      = 4;               // One enable per byte lane
   localparam int unsigned LANE_W    = DATA_W / BE_W;   // 8 bit lanes
   localparam int unsigned REG_IDX_W = 5;               // addr[6:2]
   localparam int unsigned NUM_REGS  = 1 << REG_IDX_W;  // Size of the one-hot select

   //------------------------------
   // Register map
   //------------------------------
   localparam logic [REG_IDX_W-1:0] REG_CHIP_ID   = 5'd0;
   localparam logic [REG_IDX_W-1:0] REG_FUSE_ID   = 5'd1;
   localparam logic [REG_IDX_W-1:0] REG_GPIO_IN   = 5'd2;   // Read only
   localparam logic [REG_IDX_W-1:0] REG_GPIO_OUT  = 5'd3;
   localparam logic [REG_IDX_W-1:0] REG_GPIO_DIR  = 5'd4;
   localparam logic [REG_IDX_W-1:0] REG_GPIO_TYPE = 5'd5;
   localparam logic [REG_IDX_W-1:0] REG_IRQ_CFG   = 5'd6;
   localparam logic [REG_IDX_W-1:0] REG_PULSE_1US = 5'd7;
   localparam logic [REG_IDX_W-1:0] REG_INT_CLR   = 5'd9;   // Write one to clear
   localparam logic [REG_IDX_W-1:0] REG_INT_SET   = 5'd10;  // Write one to set
   localparam logic [REG_IDX_W-1:0] REG_INT_MASK  = 5'd11;
   localparam logic [REG_IDX_W-1:0] REG_POS_SEL   = 5'd12;
   localparam logic [REG_IDX_W-1:0] REG_NEG_SEL   = 5'd13;
   localparam logic [REG_IDX_W-1:0] REG_MFUNC_SEL = 5'd14;

   // Manufacturer 8949, chip 02, revision 01
   localparam logic [DATA_W-1:0] CHIP_ID_WORD = 32'h8949_0201;
   localparam logic [DATA_W-1:0] FUSE_ID_RST  = 32'hA55A_A55A;

   //------------------------------
   // Shared types
   //------------------------------
   typedef struct packed {
      logic              cs;     // Level, held until ack
      logic              wr;
      logic [7:0]        addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   typedef struct packed {
      logic [NUM_REGS-1:0] sel;  // One-hot by index, single cycle
      logic [DATA_W-1:0]   wdata;
      logic [BE_W-1:0]     be;
   } reg_wr_t;

   // Register 6 seen as byte lanes on write and as fields on use
   typedef union packed {
      logic [BE_W-1:0][LANE_W-1:0] lanes;
      struct packed {
         logic [16:0] rsvd;      // Always zero
         logic [2:0]  user_irq;
         logic        soft_irq;
         logic [10:0] irq_en;
      } fields;
   } irq_cfg_u;

   typedef struct packed {
      logic [DATA_W-1:0] out_data;
      logic [DATA_W-1:0] dir_sel;
      logic [DATA_W-1:0] out_type;
      logic [DATA_W-1:0] posedge_sel;
      logic [DATA_W-1:0] negedge_sel;
      logic [DATA_W-1:0] multi_func_sel;
   } gpio_cfg_t;

   // Byte-enabled merge of a write into a stored word
   function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [BE_W-1:0]   be);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int i = 0; i < BE_W; i++)
      begin
         if (be[i])
            res[i*LANE_W +: LANE_W] = new_word[i*LANE_W +: LANE_W];
      end
      return res;
   endfunction

endpackage

// File: hdl/pinmux_bus_ctrl.sv
module pinmux_bus_ctrl
   import pinmux_pkg::*;
(
   input  logic              mclk,
   input  logic              h_reset_n,
   input  reg_req_t          reg_req,
   output reg_wr_t           reg_wr,
   input  logic [DATA_W-1:0] fuse_id,
   input  logic [DATA_W-1:0] gpio_in_word,
   input  irq_cfg_u          irq_cfg,
   input  logic [DATA_W-1:0] pulse_1us_word,
   input  logic [DATA_W-1:0] int_status,
   input  logic [DATA_W-1:0] int_mask,
   input  gpio_cfg_t         gpio_cfg,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack
);

   logic [REG_IDX_W-1:0] reg_idx;
   logic                 acc_go;    // Access accepted this cycle
   logic                 wr_go;
   logic [DATA_W-1:0]    rd_mux;

   assign reg_idx = reg_req.addr[6:2];        // Word index
   assign acc_go  = reg_req.cs & ~reg_ack;    // Ack cycle blocks a second hit
   assign wr_go   = acc_go & reg_req.wr;

   //------------------------------
   // Write strobes
   //------------------------------
   // Single bit shifted to the addressed slot
   assign reg_wr.sel   = {{(NUM_REGS-1){1'b0}}, wr_go} << reg_idx;
   assign reg_wr.wdata = reg_req.wdata;
   assign reg_wr.be    = reg_req.be;

   //------------------------------
   // Read path
   //------------------------------
   always_comb
   begin
      case (reg_idx)
         REG_CHIP_ID   : rd_mux = CHIP_ID_WORD;
         REG_FUSE_ID   : rd_mux = fuse_id;
         REG_GPIO_IN   : rd_mux = gpio_in_word;
         REG_GPIO_OUT  : rd_mux = gpio_cfg.out_data;
         REG_GPIO_DIR  : rd_mux = gpio_cfg.dir_sel;
         REG_GPIO_TYPE : rd_mux = gpio_cfg.out_type;
         REG_IRQ_CFG   : rd_mux = irq_cfg;
         REG_PULSE_1US : rd_mux = pulse_1us_word;
         REG_INT_CLR   : rd_mux = int_status;
         REG_INT_SET   : rd_mux = int_status;        // Mirror of status
         REG_INT_MASK  : rd_mux = int_mask;
         REG_POS_SEL   : rd_mux = gpio_cfg.posedge_sel;
         REG_NEG_SEL   : rd_mux = gpio_cfg.negedge_sel;
         REG_MFUNC_SEL : rd_mux = gpio_cfg.multi_func_sel;
         default       : rd_mux = '0;                // Holes read zero
      endcase
   end

   // Ack pulse, one cycle after cs
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         reg_ack <= 1'b0;
      else
         reg_ack <= acc_go;
   end

   // Data launched with the ack
   always_ff @(posedge mclk)
   begin
      if (acc_go)
         reg_rdata <= rd_mux;
   end

endmodule

// File: hdl/gpio_in_sync.sv
module gpio_in_sync
   import pinmux_pkg::*;
(
   input  logic              mclk,
   input  logic              h_reset_n,
   input  logic [DATA_W-1:0] gpio_in_data,      // Raw pad inputs
   output logic [DATA_W-1:0] gpio_prev_indata,  // Second stage
   output logic [DATA_W-1:0] cfg_gpio_data_in   // Third stage, register 2
);

   logic [DATA_W-1:0] gpio_in_s;   // First flop, may go metastable
   logic [DATA_W-1:0] gpio_in_ss;

   //------------------------------
   // Three stage capture
   //------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         gpio_in_s        <= '0;
         gpio_in_ss       <= '0;
         cfg_gpio_data_in <= '0;
      end
      else
      begin
         gpio_in_s        <= gpio_in_data;
         gpio_in_ss       <= gpio_in_s;    // Settled copy
         cfg_gpio_data_in <= gpio_in_ss;   // One behind, for edge compare
      end
   end

   // Edge logic compares this against register 2
   assign gpio_prev_indata = gpio_in_ss;

endmodule

// File: hdl/gpio_cfg_regs.sv
module gpio_cfg_regs
   import pinmux_pkg::*;
(
   input  logic      mclk,
   input  logic      h_reset_n,
   input  reg_wr_t   reg_wr,
   output gpio_cfg_t gpio_cfg
);

   //------------------------------
   // GPIO configuration words
   //------------------------------
   // All six are plain byte-writable words, zero out of reset
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         gpio_cfg <= '0;
      end
      else
      begin
         // Pad output value
         if (reg_wr.sel[REG_GPIO_OUT])
            gpio_cfg.out_data <= be_merge(gpio_cfg.out_data, reg_wr.wdata, reg_wr.be);

         // One selects output drive at the pad
         if (reg_wr.sel[REG_GPIO_DIR])
            gpio_cfg.dir_sel <= be_merge(gpio_cfg.dir_sel, reg_wr.wdata, reg_wr.be);

         // Static level or waveform
         if (reg_wr.sel[REG_GPIO_TYPE])
            gpio_cfg.out_type <= be_merge(gpio_cfg.out_type, reg_wr.wdata, reg_wr.be);

         if (reg_wr.sel[REG_POS_SEL])   // Rising edge interrupt enable
            gpio_cfg.posedge_sel <= be_merge(gpio_cfg.posedge_sel, reg_wr.wdata,
                                             reg_wr.be);

         if (reg_wr.sel[REG_NEG_SEL])   // Falling edge interrupt enable
            gpio_cfg.negedge_sel <= be_merge(gpio_cfg.negedge_sel, reg_wr.wdata,
                                             reg_wr.be);

         // Hands the pin over to an alternate function
         if (reg_wr.sel[REG_MFUNC_SEL])
            gpio_cfg.multi_func_sel <= be_merge(gpio_cfg.multi_func_sel, reg_wr.wdata,
                                                reg_wr.be);
      end
   end

endmodule

// File: hdl/gpio_intr_ctrl.sv
module gpio_intr_ctrl
   import pinmux_pkg::*;
(
   input  logic              mclk,
   input  logic              h_reset_n,
   input  reg_wr_t           reg_wr,
   input  logic [DATA_W-1:0] gpio_int_event,  // From the GPIO edge detect
   output logic [DATA_W-1:0] int_status,
   output logic [DATA_W-1:0] int_mask,
   output logic              gpio_intr        // To the RISC line vector
);

   logic [DATA_W-1:0] status_nxt;
   logic              clr_hit;
   logic              set_hit;

   assign clr_hit = reg_wr.sel[REG_INT_CLR];
   assign set_hit = reg_wr.sel[REG_INT_SET];

   //------------------------------
   // Status next state
   //------------------------------
   always_comb
   begin
      status_nxt = int_status;
      for (int i = 0; i < BE_W; i++)
      begin
         // Ones clear, zeros leave alone
         if (clr_hit && reg_wr.be[i])
            status_nxt[i*LANE_W +: LANE_W] = int_status[i*LANE_W +: LANE_W]
                                           & ~reg_wr.wdata[i*LANE_W +: LANE_W];
         if (set_hit && reg_wr.be[i])   // Software posting
            status_nxt[i*LANE_W +: LANE_W] = int_status[i*LANE_W +: LANE_W]
                                           | reg_wr.wdata[i*LANE_W +: LANE_W];
      end
      // Hardware events beat a clear in the same cycle
      status_nxt = status_nxt | gpio_int_event;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_status <= '0;
      else
         int_status <= status_nxt;   // Updated every cycle
   end

   //------------------------------
   // Mask and combined interrupt
   //------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_mask <= '0;
      else if (reg_wr.sel[REG_INT_MASK])
         int_mask <= be_merge(int_mask, reg_wr.wdata, reg_wr.be);
   end

   // Any unmasked pending bit
   assign gpio_intr = |(int_status & int_mask);

endmodule

// File: hdl/risc_irq_cfg.sv
module risc_irq_cfg
   import pinmux_pkg::*;
(
   input  logic              mclk,
   input  logic              h_reset_n,
   input  reg_wr_t           reg_wr,
   input  logic              gpio_intr,
   input  logic [1:0]        ext_intr_in,
   input  logic              usb_intr,
   input  logic              i2cm_intr,
   output logic [DATA_W-1:0] fuse_id,         // Readback copy
   output irq_cfg_u          irq_cfg,
   output logic [DATA_W-1:0] pulse_1us_word,
   output logic [DATA_W-1:0] fuse_mhartid,
   output logic [15:0]       irq_lines,
   output logic              soft_irq,
   output logic [2:0]        user_irq,
   output logic [9:0]        cfg_pulse_1us
);

   //------------------------------
   // Fuse hart id and 1us count
   //------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         fuse_id        <= FUSE_ID_RST;   // Nonzero default id
         pulse_1us_word <= '0;
      end
      else
      begin
         if (reg_wr.sel[REG_FUSE_ID])
            fuse_id <= be_merge(fuse_id, reg_wr.wdata, reg_wr.be);
         if (reg_wr.sel[REG_PULSE_1US])
            pulse_1us_word <= be_merge(pulse_1us_word, reg_wr.wdata, reg_wr.be);
      end
   end

   assign fuse_mhartid  = fuse_id;
   assign cfg_pulse_1us = pulse_1us_word[9:0];   // Low ten bits to the 1us counter

   //------------------------------
   // Register 6
   //------------------------------
   // Only lanes 0 and 1 carry bits; lanes 2 and 3 never load
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         irq_cfg <= '0;
      end
      else if (reg_wr.sel[REG_IRQ_CFG])
      begin
         if (reg_wr.be[0])
            irq_cfg.lanes[0] <= reg_wr.wdata[7:0];           // irq_en low byte
         if (reg_wr.be[1])
            irq_cfg.lanes[1] <= {1'b0, reg_wr.wdata[14:8]};  // Bit 15 reserved
      end
   end

   assign soft_irq  = irq_cfg.fields.soft_irq;
   assign user_irq  = irq_cfg.fields.user_irq;

   // Line vector into the RISC core
   assign irq_lines = {gpio_intr, ext_intr_in, usb_intr, i2cm_intr, irq_cfg.fields.irq_en};

endmodule

// File: hdl/pinmux_top.sv
module pinmux_top
   import pinmux_pkg::*;
(
   input  logic              mclk,
   input  logic              h_reset_n,
   input  reg_req_t          reg_req,
   output logic [DATA_W-1:0] reg_rdata,
   output logic              reg_ack,
   // GPIO side
   input  logic [DATA_W-1:0] gpio_in_data,
   input  logic [DATA_W-1:0] gpio_int_event,
   output logic [DATA_W-1:0] gpio_prev_indata,
   output logic [DATA_W-1:0] cfg_gpio_data_in,
   output logic [DATA_W-1:0] cfg_gpio_out_data,
   output logic [DATA_W-1:0] cfg_gpio_dir_sel,
   output logic [DATA_W-1:0] cfg_gpio_out_type,
   output logic [DATA_W-1:0] cfg_gpio_posedge_int_sel,
   output logic [DATA_W-1:0] cfg_gpio_negedge_int_sel,
   output logic [DATA_W-1:0] cfg_multi_func_sel,
   // RISC side
   input  logic [1:0]        ext_intr_in,
   input  logic              usb_intr,
   input  logic              i2cm_intr,
   output logic [DATA_W-1:0] fuse_mhartid,
   output logic [15:0]       irq_lines,
   output logic              soft_irq,
   output logic [2:0]        user_irq,
   output logic [9:0]        cfg_pulse_1us
);

   reg_wr_t           reg_wr;
   gpio_cfg_t         gpio_cfg;
   irq_cfg_u          irq_cfg;
   logic [DATA_W-1:0] fuse_id;
   logic [DATA_W-1:0] pulse_1us_word;
   logic [DATA_W-1:0] int_status;
   logic [DATA_W-1:0] int_mask;
   logic              gpio_intr;

   //------------------------------
   // Bus decode and readback
   //------------------------------
   pinmux_bus_ctrl u_bus_ctrl (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .reg_req        (reg_req),
      .reg_wr         (reg_wr),
      .fuse_id        (fuse_id),
      .gpio_in_word   (cfg_gpio_data_in),
      .irq_cfg        (irq_cfg),
      .pulse_1us_word (pulse_1us_word),
      .int_status     (int_status),
      .int_mask       (int_mask),
      .gpio_cfg       (gpio_cfg),
      .reg_rdata      (reg_rdata),
      .reg_ack        (reg_ack)
   );

   //------------------------------
   // GPIO blocks
   //------------------------------
   gpio_in_sync u_gpio_in_sync (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_prev_indata (gpio_prev_indata),
      .cfg_gpio_data_in (cfg_gpio_data_in)
   );

   gpio_cfg_regs u_gpio_cfg_regs (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .reg_wr    (reg_wr),
      .gpio_cfg  (gpio_cfg)
   );

   // Struct fanned out to the pad control
   assign cfg_gpio_out_data        = gpio_cfg.out_data;
   assign cfg_gpio_dir_sel         = gpio_cfg.dir_sel;
   assign cfg_gpio_out_type        = gpio_cfg.out_type;
   assign cfg_gpio_posedge_int_sel = gpio_cfg.posedge_sel;
   assign cfg_gpio_negedge_int_sel = gpio_cfg.negedge_sel;
   assign cfg_multi_func_sel       = gpio_cfg.multi_func_sel;

   gpio_intr_ctrl u_gpio_intr_ctrl (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .reg_wr         (reg_wr),
      .gpio_int_event (gpio_int_event),
      .int_status     (int_status),
      .int_mask       (int_mask),
      .gpio_intr      (gpio_intr)
   );

   //------------------------------
   // RISC configuration
   //------------------------------
   risc_irq_cfg u_risc_irq_cfg (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .reg_wr         (reg_wr),
      .gpio_intr      (gpio_intr),
      .ext_intr_in    (ext_intr_in),
      .usb_intr       (usb_intr),
      .i2cm_intr      (i2cm_intr),
      .fuse_id        (fuse_id),
      .irq_cfg        (irq_cfg),
      .pulse_1us_word (pulse_1us_word),
      .fuse_mhartid   (fuse_mhartid),
      .irq_lines      (irq_lines),
      .soft_irq       (soft_irq),
      .user_irq       (user_irq),
      .cfg_pulse_1us  (cfg_pulse_1us)
   );

endmodule

// File: tests/pinmux_tb.sv
module pinmux_tb
   import pinmux_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   // Tests take about 300 cycles of bus traffic
   localparam int MAX_CYCLES = 2000;
   localparam int ACK_LIMIT  = 8;     // Cycles allowed from cs to ack

   logic              mclk;
   logic              h_reset_n;
   reg_req_t          reg_req;
   logic [DATA_W-1:0] reg_rdata;
   logic              reg_ack;
   logic [DATA_W-1:0] gpio_in_data;
   logic [DATA_W-1:0] gpio_int_event;
   logic [DATA_W-1:0] gpio_prev_indata;
   logic [DATA_W-1:0] cfg_gpio_data_in;
   logic [DATA_W-1:0] cfg_gpio_out_data;
   logic [DATA_W-1:0] cfg_gpio_dir_sel;
   logic [DATA_W-1:0] cfg_gpio_out_type;
   logic [DATA_W-1:0] cfg_gpio_posedge_int_sel;
   logic [DATA_W-1:0] cfg_gpio_negedge_int_sel;
   logic [DATA_W-1:0] cfg_multi_func_sel;
   logic [1:0]        ext_intr_in;
   logic              usb_intr;
   logic              i2cm_intr;
   logic [DATA_W-1:0] fuse_mhartid;
   logic [15:0]       irq_lines;
   logic              soft_irq;
   logic [2:0]        user_irq;
   logic [9:0]        cfg_pulse_1us;

   gpio_cfg_t         cfg_out;        // Six pad outputs regrouped
   gpio_cfg_t         cfg_model;
   logic [DATA_W-1:0] status_model;
   logic [DATA_W-1:0] mask_model;
   logic [DATA_W-1:0] irq6_model;     // Register 6 as the bus sees it
   int                cycle_cnt = 0;

   //------------------------------
   // Clock and DUT
   //------------------------------
   always #20 mclk = ~mclk;   // 40 ns period

   pinmux_top uut (
      .mclk                     (mclk),
      .h_reset_n                (h_reset_n),
      .reg_req                  (reg_req),
      .reg_rdata                (reg_rdata),
      .reg_ack                  (reg_ack),
      .gpio_in_data             (gpio_in_data),
      .gpio_int_event           (gpio_int_event),
      .gpio_prev_indata         (gpio_prev_indata),
      .cfg_gpio_data_in         (cfg_gpio_data_in),
      .cfg_gpio_out_data        (cfg_gpio_out_data),
      .cfg_gpio_dir_sel         (cfg_gpio_dir_sel),
      .cfg_gpio_out_type        (cfg_gpio_out_type),
      .cfg_gpio_posedge_int_sel (cfg_gpio_posedge_int_sel),
      .cfg_gpio_negedge_int_sel (cfg_gpio_negedge_int_sel),
      .cfg_multi_func_sel       (cfg_multi_func_sel),
      .ext_intr_in              (ext_intr_in),
      .usb_intr                 (usb_intr),
      .i2cm_intr                (i2cm_intr),
      .fuse_mhartid             (fuse_mhartid),
      .irq_lines                (irq_lines),
      .soft_irq                 (soft_irq),
      .user_irq                 (user_irq),
      .cfg_pulse_1us            (cfg_pulse_1us)
   );

   // Same field order as gpio_cfg_t
   assign cfg_out = {cfg_gpio_out_data, cfg_gpio_dir_sel, cfg_gpio_out_type,
                     cfg_gpio_posedge_int_sel, cfg_gpio_negedge_int_sel, cfg_multi_func_sel};

   // Run length guard
   always @(posedge mclk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
         stop_run();
      end
   end

   //------------------------------
   // Error exit and compares
   //------------------------------
   task automatic stop_run();
      $display("Something failed");
      $fatal(1, "Run stopped on first error");
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s: got %h, expected %h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_cfg(input gpio_cfg_t got, input gpio_cfg_t exp);
      check_word("cfg_gpio_out_data", got.out_data, exp.out_data);
      check_word("cfg_gpio_dir_sel", got.dir_sel, exp.dir_sel);
      check_word("cfg_gpio_out_type", got.out_type, exp.out_type);
      check_word("cfg_gpio_posedge_int_sel", got.posedge_sel, exp.posedge_sel);
      check_word("cfg_gpio_negedge_int_sel", got.negedge_sel, exp.negedge_sel);
      check_word("cfg_multi_func_sel", got.multi_func_sel, exp.multi_func_sel);
   endtask

   task automatic check_irq(input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH irq_lines: got %h, expected %h", got, exp);
         stop_run();
      end
   endtask

   //------------------------------
   // Reference model helpers
   //------------------------------
   // Byte enables spread to a bit mask
   function automatic logic [DATA_W-1:0] lane_mask(input logic [BE_W-1:0] be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   function automatic logic [REG_IDX_W-1:0] cfg_index(input int n);
      case (n)
         0       : return REG_GPIO_OUT;
         1       : return REG_GPIO_DIR;
         2       : return REG_GPIO_TYPE;
         3       : return REG_POS_SEL;
         4       : return REG_NEG_SEL;
         default : return REG_MFUNC_SEL;
      endcase
   endfunction

   task automatic update_cfg_model(input logic [REG_IDX_W-1:0] idx,
                                   input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] m;
      m = lane_mask(be);
      case (idx)
         REG_GPIO_OUT  : cfg_model.out_data       = (cfg_model.out_data & ~m) | (d & m);
         REG_GPIO_DIR  : cfg_model.dir_sel        = (cfg_model.dir_sel & ~m) | (d & m);
         REG_GPIO_TYPE : cfg_model.out_type       = (cfg_model.out_type & ~m) | (d & m);
         REG_POS_SEL   : cfg_model.posedge_sel    = (cfg_model.posedge_sel & ~m) | (d & m);
         REG_NEG_SEL   : cfg_model.negedge_sel    = (cfg_model.negedge_sel & ~m) | (d & m);
         REG_MFUNC_SEL : cfg_model.multi_func_sel = (cfg_model.multi_func_sel & ~m) | (d & m);
         default       : ;
      endcase
   endtask

   function automatic logic [DATA_W-1:0] cfg_model_word(input logic [REG_IDX_W-1:0] idx);
      case (idx)
         REG_GPIO_OUT  : return cfg_model.out_data;
         REG_GPIO_DIR  : return cfg_model.dir_sel;
         REG_GPIO_TYPE : return cfg_model.out_type;
         REG_POS_SEL   : return cfg_model.posedge_sel;
         REG_NEG_SEL   : return cfg_model.negedge_sel;
         default       : return cfg_model.multi_func_sel;
      endcase
   endfunction

   // Bit 15 down to bit 0 of the RISC line vector
   function automatic logic [15:0] expected_irq_lines();
      return {|(status_model & mask_model), ext_intr_in, usb_intr, i2cm_intr,
              irq6_model[10:0]};
   endfunction

   task automatic compare_risc_outputs();
      check_irq(irq_lines, expected_irq_lines());
      check_word("soft_irq", {31'b0, soft_irq}, {31'b0, irq6_model[11]});
      check_word("user_irq", {29'b0, user_irq}, {29'b0, irq6_model[14:12]});
   endtask

   //------------------------------
   // Bus tasks
   //------------------------------
   task automatic bus_access(input logic wr, input logic [REG_IDX_W-1:0] idx,
                             input logic [DATA_W-1:0] d, input logic [BE_W-1:0] be,
                             output logic [DATA_W-1:0] rd);
      int waited;
      waited = 0;
      @(posedge mclk);
      reg_req.cs    <= 1'b1;
      reg_req.wr    <= wr;
      reg_req.addr  <= {1'b0, idx, 2'b00};   // Word address
      reg_req.wdata <= d;
      reg_req.be    <= be;
      do
      begin
         @(negedge mclk);
         waited++;
         if (!reg_ack && waited >= ACK_LIMIT)
         begin
            $display("ERROR: no reg_ack within %0d cycles for index %0d", ACK_LIMIT, idx);
            stop_run();
         end
      end
      while (!reg_ack);
      rd = reg_rdata;          // Valid with the ack
      @(posedge mclk);
      reg_req.cs <= 1'b0;
      @(negedge mclk);
      check_word("reg_ack", {31'b0, reg_ack}, '0);   // Single cycle pulse
   endtask

   task automatic bus_write(input logic [REG_IDX_W-1:0] idx, input logic [DATA_W-1:0] d,
                            input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] ignored;
      bus_access(1'b1, idx, d, be, ignored);
   endtask

   task automatic bus_read(input logic [REG_IDX_W-1:0] idx, output logic [DATA_W-1:0] rd);
      bus_access(1'b0, idx, '0, 4'hF, rd);
   endtask

   //------------------------------
   // Directed tests
   //------------------------------
   task automatic reset_values();
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] exp;
      @(negedge mclk);
      check_word("reg_ack", {31'b0, reg_ack}, '0);
      check_word("fuse_mhartid", fuse_mhartid, 32'hA55A_A55A);
      check_cfg(cfg_out, cfg_model);
      compare_risc_outputs();
      for (int i = 0; i < 32; i++)
      begin
         bus_read(5'(i), rd);
         exp = (i == 0) ? 32'h8949_0201 : ((i == 1) ? 32'hA55A_A55A : 32'h0);
         check_word($sformatf("reg_rdata[%0d]", i), rd, exp);
      end
   endtask

   task automatic gpio_cfg_rw();
      logic [REG_IDX_W-1:0] idx;
      logic [DATA_W-1:0]    d;
      logic [BE_W-1:0]      be;
      logic [DATA_W-1:0]    rd;
      for (int n = 0; n < 18; n++)
      begin
         idx = cfg_index($urandom_range(0, 5));
         d   = $urandom();
         be  = (n % 3 == 0) ? 4'hF : 4'($urandom_range(1, 14));   // Partial lanes mostly
         bus_write(idx, d, be);
         update_cfg_model(idx, d, be);
         check_cfg(cfg_out, cfg_model);
      end
      for (int k = 0; k < 6; k++)
      begin
         bus_read(cfg_index(k), rd);
         check_word($sformatf("reg_rdata[%0d]", cfg_index(k)), rd, cfg_model_word(cfg_index(k)));
      end
      // Unmapped index
      bus_write(5'd20, $urandom(), 4'hF);
      check_cfg(cfg_out, cfg_model);
      bus_read(5'd20, rd);
      check_word("reg_rdata[20]", rd, '0);
   endtask

   task automatic input_capture();
      logic [DATA_W-1:0] pins;
      logic [DATA_W-1:0] rd;
      pins = $urandom();
      @(posedge mclk);
      gpio_in_data <= pins;
      repeat (2) @(posedge mclk);
      @(negedge mclk);
      check_word("gpio_prev_indata", gpio_prev_indata, pins);   // Two stages in
      @(negedge mclk);
      check_word("cfg_gpio_data_in", cfg_gpio_data_in, pins);
      bus_read(REG_GPIO_IN, rd);
      check_word("reg_rdata[2]", rd, pins);
   endtask

   task automatic intr_status();
      logic [DATA_W-1:0] ev;
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] rd;
      bus_write(REG_INT_MASK, 32'hFFFF_FFFF, 4'hF);
      mask_model = 32'hFFFF_FFFF;
      ev = $urandom() | 32'h1;   // At least one bit set
      @(posedge mclk);
      gpio_int_event <= ev;
      @(posedge mclk);
      gpio_int_event <= '0;      // One cycle pulse
      status_model = status_model | ev;
      @(negedge mclk);
      check_irq(irq_lines, expected_irq_lines());
      bus_read(REG_INT_CLR, rd);
      check_word("int_status", rd, status_model);
      // Clear in lanes 0 and 2 only
      d = $urandom();
      bus_write(REG_INT_CLR, d, 4'b0101);
      status_model = status_model & ~(d & lane_mask(4'b0101));
      bus_read(REG_INT_CLR, rd);
      check_word("int_status", rd, status_model);
      check_irq(irq_lines, expected_irq_lines());
      d = $urandom();
      bus_write(REG_INT_SET, d, 4'b1110);
      status_model = status_model | (d & lane_mask(4'b1110));
      bus_read(REG_INT_SET, rd);
      check_word("int_status", rd, status_model);
      d = $urandom();
      bus_write(REG_INT_MASK, d, 4'hF);
      mask_model = d;
      bus_read(REG_INT_MASK, rd);
      check_word("int_mask", rd, mask_model);
      check_irq(irq_lines, expected_irq_lines());
      // Clearing everything drops the line
      bus_write(REG_INT_CLR, 32'hFFFF_FFFF, 4'hF);
      status_model = '0;
      check_irq(irq_lines, expected_irq_lines());
   endtask

   task automatic risc_irq_setup();
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] rd;
      logic [BE_W-1:0]   be;
      for (int n = 0; n < 4; n++)
      begin
         d  = (n == 3) ? 32'hFFFF_FFFF : $urandom();
         be = (n == 3) ? 4'hF : 4'($urandom_range(1, 15));
         bus_write(REG_IRQ_CFG, d, be);
         // Only bits 14 to 0 exist in register 6
         irq6_model = ((irq6_model & ~lane_mask(be)) | (d & lane_mask(be))) & 32'h0000_7FFF;
         compare_risc_outputs();
         bus_read(REG_IRQ_CFG, rd);
         check_word("reg_rdata[6]", rd, irq6_model);
      end
      for (int n = 0; n < 6; n++)
      begin
         @(posedge mclk);
         ext_intr_in <= 2'($urandom_range(0, 3));
         usb_intr    <= 1'($urandom_range(0, 1));
         i2cm_intr   <= 1'($urandom_range(0, 1));
         @(negedge mclk);
         compare_risc_outputs();
      end
      d = $urandom();
      bus_write(REG_PULSE_1US, d, 4'hF);
      check_word("cfg_pulse_1us", {22'b0, cfg_pulse_1us}, {22'b0, d[9:0]});
      bus_read(REG_PULSE_1US, rd);
      check_word("reg_rdata[7]", rd, d);
   endtask

   //------------------------------
   // Main sequence
   //------------------------------
   initial
   begin
      void'($urandom(32'he3de));
      mclk           = 1'b0;
      h_reset_n      = 1'b0;
      reg_req        = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      ext_intr_in    = '0;
      usb_intr       = 1'b0;
      i2cm_intr      = 1'b0;
      cfg_model      = '0;
      status_model   = '0;
      mask_model     = '0;
      irq6_model     = '0;
      repeat (10) @(posedge mclk);
      h_reset_n <= 1'b1;
      reset_values();
      gpio_cfg_rw();
      input_capture();
      intr_status();
      risc_irq_setup();
      $display("Everything OK");
      $finish;
   end

endmodule

// File: sim.f
hdl/pinmux_pkg.sv
hdl/pinmux_bus_ctrl.sv
hdl/gpio_in_sync.sv
hdl/gpio_cfg_regs.sv
hdl/gpio_intr_ctrl.sv
hdl/risc_irq_cfg.sv
hdl/pinmux_top.sv
tests/pinmux_tb.sv

// File: Makefile
# Verilator build for the pin-mux register block

VERILATOR ?= verilator
TOP       ?= pinmux_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=

SRCS   := $(wildcard hdl/*.sv tests/*.sv)
COMMON  = --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP) $(VFLAGS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(COMMON) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
